// ==== cutter_stream_pkg.sv ====
package cutter_stream_pkg;

	// Stream geometry
	localparam int data_width  = 256;
	localparam int strb_width  = data_width / 8;   // One strobe bit per byte
	localparam int tuser_width = 128;

	localparam int count_width     = 32;          // Width of cut_words
	localparam int fifo_depth_bits = 3;           // Input buffer holds 8 words

	// One stream beat as it sits in the input buffer
	typedef struct packed {
		logic [data_width-1:0]  data;
		logic [strb_width-1:0]  strb;
		logic [tuser_width-1:0] user;
		logic                   last;
	} stream_word_t;

	// Widen each strobe bit to cover its byte lane
	// Strobe bit i covers data bits 8*i+7 down to 8*i
	function automatic logic [data_width-1:0] strb_to_mask(
		input logic [strb_width-1:0] strb
	);
		logic [data_width-1:0] mask;
		for (int i = 0; i < strb_width; i++) begin
			mask[8*i +: 8] = {8{strb[i]}};
		end
		return mask;
	endfunction

endpackage

// ==== cutter_hash_pkg.sv ====
package cutter_hash_pkg;

	import cutter_stream_pkg::*;

	localparam int hash_width = 128;               // Folded digest
	localparam int hash_bytes = hash_width / 8;

	// Digest sits in the upper byte lanes
	localparam logic [strb_width-1:0] hash_strb =
		{{hash_bytes{1'b1}}, {(strb_width - hash_bytes){1'b0}}};

	// Running XOR over the dropped tail, one full data word wide
	typedef logic [data_width-1:0] acc_t;

	// Fold the accumulator down to the digest width
	function automatic logic [hash_width-1:0] fold_hash(input acc_t acc);
		return acc[hash_width-1:0] ^ acc[2*hash_width-1:hash_width];
	endfunction

	// Digest in the top bytes of a data word, rest zero
	function automatic logic [data_width-1:0] digest_word(
		input logic [hash_width-1:0] digest
	);
		return {digest, {(data_width - hash_width){1'b0}}};
	endfunction

endpackage

// ==== stream_fifo.sv ====
`timescale 1ns/1ps

module stream_fifo #(
	parameter type payload_t  = logic [7:0],
	parameter int  depth_bits = 3
) (
	input  logic     axi_aclk,
	input  logic     axi_resetn,
	input  payload_t din,
	input  logic     wr_en,
	input  logic     rd_en,
	output payload_t dout,
	output logic     empty,
	output logic     nearly_full
);

	localparam int depth = 2 ** depth_bits;

	payload_t mem [depth];

	logic [depth_bits-1:0] wr_ptr;
	logic [depth_bits-1:0] rd_ptr;
	logic [depth_bits:0]   count;       // One extra bit to tell full from empty
	logic                  full;

	assign dout        = mem[rd_ptr];  // Head shows without a read
	assign empty       = (count == '0);
	assign full        = (count == depth);
	assign nearly_full = (count >= depth - 1); // Room for a write already on its way

	always_ff @(posedge axi_aclk) begin
		if (wr_en) begin
			mem[wr_ptr] <= din;
		end
	end

	always_ff @(posedge axi_aclk) begin
		if (!axi_resetn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_en) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (rd_en) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({wr_en, rd_en})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;   // Both or neither
			endcase
		end
	end

	// Upstream must respect nearly_full
	a_no_overflow: assert property (
		@(posedge axi_aclk) disable iff (!axi_resetn)
		!(wr_en && full)
	) else $error("stream_fifo write while full");

	// Consumer only pops a word it has seen at the head
	a_no_underflow: assert property (
		@(posedge axi_aclk) disable iff (!axi_resetn)
		!(rd_en && empty)
	) else $error("stream_fifo read while empty");

endmodule

// ==== cut_control.sv ====
`timescale 1ns/1ps

module cut_control
	import cutter_stream_pkg::*;
	import cutter_hash_pkg::*;
(
	input  logic                   axi_aclk,
	input  logic                   axi_resetn,
	input  logic                   cut_en,
	input  logic [count_width-1:0] cut_words,
	input  stream_word_t           head,
	input  logic                   empty,
	output logic                   rd_en,
	output stream_word_t           out_word,
	output logic                   out_valid,
	input  logic                   out_ready,
	output logic                   acc_clear,
	output logic                   acc_absorb,
	input  logic [hash_width-1:0]  digest
);

	typedef enum logic [3:0] {
		s_wait   = 4'b0001,   // Head is a first word
		s_pass   = 4'b0010,
		s_absorb = 4'b0100,   // Dropping the tail into the hash
		s_digest = 4'b1000
	} state_t;

	state_t                 state;
	state_t                 state_next;
	logic                   cut_act;       // Cut in force for this packet
	logic                   cut_act_next;
	logic [count_width-1:0] count;         // Words still to pass before the cut
	logic [count_width-1:0] count_next;
	logic [tuser_width-1:0] last_user;

	logic                   first;
	logic                   active;
	logic [count_width-1:0] remaining;

	// On a first word the live config applies, later the latched one
	assign first     = (state == s_wait);
	assign active    = first ? (cut_en && (cut_words != '0)) : cut_act;
	assign remaining = first ? cut_words : count;

	always_comb begin
		state_next   = state;
		cut_act_next = cut_act;
		count_next   = count;
		rd_en        = 1'b0;
		out_word     = head;
		out_valid    = 1'b0;
		acc_clear    = 1'b0;
		acc_absorb   = 1'b0;

		case (state)
			s_wait, s_pass: begin
				out_valid = !empty;
				if (!empty && out_ready) begin
					rd_en        = 1'b1;
					acc_clear    = first;     // Fresh hash per packet
					cut_act_next = active;
					count_next   = remaining - 1'b1;
					if (head.last) begin
						state_next = s_wait;
					end else if (active && (remaining == count_width'(1))) begin
						state_next = s_absorb;   // Last kept word, tail follows
					end else begin
						state_next = s_pass;
					end
				end
			end

			s_absorb: begin
				if (!empty) begin
					rd_en      = 1'b1;
					acc_absorb = 1'b1;
					if (head.last) begin
						state_next = s_digest;
					end
				end
			end

			s_digest: begin
				out_word.data = digest_word(digest);
				out_word.strb = hash_strb;
				out_word.user = last_user;
				out_word.last = 1'b1;
				out_valid     = 1'b1;
				if (out_ready) begin
					state_next = s_wait;
				end
			end

			default: state_next = s_wait;
		endcase
	end

	always_ff @(posedge axi_aclk) begin
		if (!axi_resetn) begin
			state   <= s_wait;
			cut_act <= 1'b0;
			count   <= '0;
		end else begin
			state   <= state_next;
			cut_act <= cut_act_next;
			count   <= count_next;
		end
	end

	// Closing word takes the user data of the packet's last input word
	always_ff @(posedge axi_aclk) begin
		if (acc_absorb && head.last) begin
			last_user <= head.user;
		end
	end

	a_state_legal: assert property (
		@(posedge axi_aclk) disable iff (!axi_resetn)
		$onehot(state)
	) else $error("cut_control state not one-hot");

endmodule

// ==== hash_accumulator.sv ====
`timescale 1ns/1ps

module hash_accumulator
	import cutter_stream_pkg::*;
	import cutter_hash_pkg::*;
(
	input  logic                  axi_aclk,
	input  logic                  axi_resetn,
	input  logic                  acc_clear,
	input  logic                  acc_absorb,
	input  logic [data_width-1:0] tdata,
	input  logic [strb_width-1:0] tstrb,
	output logic [hash_width-1:0] digest
);

	acc_t acc;
	acc_t masked;

	// Bytes with a low strobe bit do not count
	assign masked = tdata & strb_to_mask(tstrb);

	always_ff @(posedge axi_aclk) begin
		if (!axi_resetn) begin
			acc <= '0;
		end else if (acc_clear) begin
			// Clear wins but keeps a word absorbed in the same cycle
			acc <= acc_absorb ? masked : '0;
		end else if (acc_absorb) begin
			acc <= acc ^ masked;
		end
	end

	assign digest = fold_hash(acc);   // Straight from the register

endmodule

// ==== output_slice.sv ====
`timescale 1ns/1ps

module output_slice
	import cutter_stream_pkg::*;
(
	input  logic                   axi_aclk,
	input  logic                   axi_resetn,
	input  stream_word_t           in_word,
	input  logic                   in_valid,
	output logic                   in_ready,
	output logic [data_width-1:0]  m_axis_tdata,
	output logic [strb_width-1:0]  m_axis_tstrb,
	output logic [tuser_width-1:0] m_axis_tuser,
	output logic                   m_axis_tlast,
	output logic                   m_axis_tvalid,
	input  logic                   m_axis_tready
);

	logic load;

	// Accept when empty or when the held word leaves this cycle
	assign in_ready = !m_axis_tvalid || m_axis_tready;
	assign load     = in_valid && in_ready;

	always_ff @(posedge axi_aclk) begin
		if (!axi_resetn) begin
			m_axis_tvalid <= 1'b0;
		end else if (load) begin
			m_axis_tvalid <= 1'b1;
		end else if (m_axis_tready) begin
			m_axis_tvalid <= 1'b0;   // Drained
		end
	end

	always_ff @(posedge axi_aclk) begin
		if (load) begin
			m_axis_tdata <= in_word.data;
			m_axis_tstrb <= in_word.strb;
			m_axis_tuser <= in_word.user;
			m_axis_tlast <= in_word.last;
		end
	end

	a_hold_stalled: assert property (
		@(posedge axi_aclk) disable iff (!axi_resetn)
		m_axis_tvalid && !m_axis_tready |=> m_axis_tvalid && $stable(m_axis_tdata)
			&& $stable(m_axis_tstrb) && $stable(m_axis_tuser) && $stable(m_axis_tlast)
	) else $error("output_slice changed a stalled word");

endmodule

// ==== packet_cutter.sv ====
`timescale 1ns/1ps

module packet_cutter
	import cutter_stream_pkg::*;
	import cutter_hash_pkg::*;
(
	input  logic                   axi_aclk,
	input  logic                   axi_resetn,

	input  logic [data_width-1:0]  s_axis_tdata,
	input  logic [strb_width-1:0]  s_axis_tstrb,
	input  logic [tuser_width-1:0] s_axis_tuser,
	input  logic                   s_axis_tvalid,
	output logic                   s_axis_tready,
	input  logic                   s_axis_tlast,

	output logic [data_width-1:0]  m_axis_tdata,
	output logic [strb_width-1:0]  m_axis_tstrb,
	output logic [tuser_width-1:0] m_axis_tuser,
	output logic                   m_axis_tvalid,
	input  logic                   m_axis_tready,
	output logic                   m_axis_tlast,

	input  logic                   cut_en,
	input  logic [count_width-1:0] cut_words
);

	stream_word_t           in_word;
	stream_word_t           head;
	stream_word_t           out_word;
	logic                   fifo_wr_en;
	logic                   fifo_rd_en;
	logic                   fifo_empty;
	logic                   fifo_nearly_full;
	logic                   out_valid;
	logic                   out_ready;
	logic                   acc_clear;
	logic                   acc_absorb;
	logic [hash_width-1:0]  digest;

	assign in_word       = '{data: s_axis_tdata, strb: s_axis_tstrb,
	                         user: s_axis_tuser, last: s_axis_tlast};
	assign s_axis_tready = !fifo_nearly_full;
	assign fifo_wr_en    = s_axis_tvalid && s_axis_tready;

	stream_fifo #(
		.payload_t  (stream_word_t),
		.depth_bits (fifo_depth_bits)
	) stream_fifo_i (
		.axi_aclk    (axi_aclk),
		.axi_resetn  (axi_resetn),
		.din         (in_word),
		.wr_en       (fifo_wr_en),
		.rd_en       (fifo_rd_en),
		.dout        (head),
		.empty       (fifo_empty),
		.nearly_full (fifo_nearly_full)
	);

	cut_control cut_control_i (
		.axi_aclk   (axi_aclk),
		.axi_resetn (axi_resetn),
		.cut_en     (cut_en),
		.cut_words  (cut_words),
		.head       (head),
		.empty      (fifo_empty),
		.rd_en      (fifo_rd_en),
		.out_word   (out_word),
		.out_valid  (out_valid),
		.out_ready  (out_ready),
		.acc_clear  (acc_clear),
		.acc_absorb (acc_absorb),
		.digest     (digest)
	);

	// Hash sees the head word directly, absorb qualifies it
	hash_accumulator hash_accumulator_i (
		.axi_aclk   (axi_aclk),
		.axi_resetn (axi_resetn),
		.acc_clear  (acc_clear),
		.acc_absorb (acc_absorb),
		.tdata      (head.data),
		.tstrb      (head.strb),
		.digest     (digest)
	);

	output_slice output_slice_i (
		.axi_aclk      (axi_aclk),
		.axi_resetn    (axi_resetn),
		.in_word       (out_word),
		.in_valid      (out_valid),
		.in_ready      (out_ready),
		.m_axis_tdata  (m_axis_tdata),
		.m_axis_tstrb  (m_axis_tstrb),
		.m_axis_tuser  (m_axis_tuser),
		.m_axis_tlast  (m_axis_tlast),
		.m_axis_tvalid (m_axis_tvalid),
		.m_axis_tready (m_axis_tready)
	);

endmodule

// ==== tb_packet_cutter.sv ====
`timescale 1ns/1ps

module tb_packet_cutter
	import cutter_stream_pkg::*;
();

	localparam logic [31:0] lfsr_seed = 32'h71d490c9;
	localparam logic [31:0] lfsr_taps = 32'h80200003;  // x^32 + x^22 + x^2 + x + 1
	localparam int total_pkts      = 130;              // Sum over all tests below
	localparam int watchdog_cycles = total_pkts * 8 * 40 + 100;

	typedef struct packed {
		logic [data_width-1:0]  data;
		logic [strb_width-1:0]  strb;
		logic [tuser_width-1:0] user;
		logic                   last;
	} exp_word_t;

	logic axi_aclk;
	logic axi_resetn;
	logic [data_width-1:0]  s_axis_tdata;
	logic [strb_width-1:0]  s_axis_tstrb;
	logic [tuser_width-1:0] s_axis_tuser;
	logic s_axis_tvalid, s_axis_tready, s_axis_tlast;
	logic [data_width-1:0]  m_axis_tdata;
	logic [strb_width-1:0]  m_axis_tstrb;
	logic [tuser_width-1:0] m_axis_tuser;
	logic m_axis_tvalid, m_axis_tready, m_axis_tlast;
	logic cut_en;
	logic [count_width-1:0] cut_words;

	logic [31:0] stim_lfsr;
	logic [31:0] bp_lfsr;          // Separate stream for m_axis_tready
	logic        bp_enable;
	logic        gap_enable;
	logic        tready_low_seen;
	int          errors;
	int          words_checked;
	int          tests_run;

	logic [data_width-1:0]  pkt_data [8];
	logic [strb_width-1:0]  pkt_strb [8];
	logic [tuser_width-1:0] pkt_user [8];
	exp_word_t exp_q [$];
	exp_word_t exp_w;

	packet_cutter packet_cutter_i (
		.axi_aclk      (axi_aclk),
		.axi_resetn    (axi_resetn),
		.s_axis_tdata  (s_axis_tdata),
		.s_axis_tstrb  (s_axis_tstrb),
		.s_axis_tuser  (s_axis_tuser),
		.s_axis_tvalid (s_axis_tvalid),
		.s_axis_tready (s_axis_tready),
		.s_axis_tlast  (s_axis_tlast),
		.m_axis_tdata  (m_axis_tdata),
		.m_axis_tstrb  (m_axis_tstrb),
		.m_axis_tuser  (m_axis_tuser),
		.m_axis_tvalid (m_axis_tvalid),
		.m_axis_tready (m_axis_tready),
		.m_axis_tlast  (m_axis_tlast),
		.cut_en        (cut_en),
		.cut_words     (cut_words)
	);

	always #2 axi_aclk = ~axi_aclk;

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ lfsr_taps;
		end
		return s >> 1;
	endfunction

	// One LFSR step per bit, first bit taken ends up in the MSB
	task automatic take_bits(inout logic [31:0] state, input int n, output logic [255:0] bits);
		bits = '0;
		for (int k = 0; k < n; k++) begin
			bits  = {bits[254:0], state[0]};
			state = lfsr_next(state);
		end
	endtask

	// Expected output for the packet in pkt_* under the given config
	function automatic void build_expected(input int len, input logic en, input logic [31:0] words);
		logic [data_width-1:0] acc;
		logic [data_width-1:0] masked;
		exp_word_t w;
		int keep;
		acc  = '0;
		keep = (en && words != 0 && len > words) ? int'(words) : len;
		for (int i = 0; i < keep; i++) begin
			w.data = pkt_data[i];
			w.strb = pkt_strb[i];
			w.user = pkt_user[i];
			w.last = (i == len - 1);
			exp_q.push_back(w);
		end
		if (keep < len) begin
			for (int i = keep; i < len; i++) begin
				for (int b = 0; b < strb_width; b++) begin
					masked[8*b +: 8] = pkt_strb[i][b] ? pkt_data[i][8*b +: 8] : 8'h00;
				end
				acc = acc ^ masked;
			end
			w.data = {acc[255:128] ^ acc[127:0], 128'h0};   // Fold, then upper lanes
			w.strb = 32'hffff_0000;
			w.user = pkt_user[len-1];
			w.last = 1'b1;
			exp_q.push_back(w);
		end
	endfunction

	// Hold the word until a cycle with s_axis_tready high
	task automatic drive_word(input int i, input logic last);
		logic done;
		done = 1'b0;
		while (!done) begin
			@(negedge axi_aclk);
			s_axis_tdata  = pkt_data[i];
			s_axis_tstrb  = pkt_strb[i];
			s_axis_tuser  = pkt_user[i];
			s_axis_tlast  = last;
			s_axis_tvalid = 1'b1;
			done          = s_axis_tready;
		end
	endtask

	task automatic send_packet(input logic en, input logic [31:0] words);
		logic [255:0] r;
		int len;
		int nbytes;
		take_bits(stim_lfsr, 3, r);
		len = r[2:0] + 1;
		for (int i = 0; i < len; i++) begin
			take_bits(stim_lfsr, 256, r);
			pkt_data[i] = r;
			take_bits(stim_lfsr, 128, r);
			pkt_user[i] = r[127:0];
			pkt_strb[i] = '1;
		end
		take_bits(stim_lfsr, 5, r);
		nbytes = r[4:0] + 1;
		pkt_strb[len-1] = {strb_width{1'b1}} << (strb_width - nbytes);  // MSB lanes first
		build_expected(len, en, words);
		for (int i = 0; i < len; i++) begin
			if (gap_enable) begin
				take_bits(stim_lfsr, 2, r);
				repeat (r[1:0]) begin
					@(negedge axi_aclk);
					s_axis_tvalid = 1'b0;
				end
			end
			drive_word(i, i == len - 1);
		end
	endtask

	task automatic run_test(input string name, input logic en, input logic [31:0] words,
			input int n_pkts, input logic gaps, input logic bp);
		int errors_before;
		errors_before = errors;
		@(negedge axi_aclk);
		cut_en          = en;
		cut_words       = words;
		gap_enable      = gaps;
		bp_enable       = bp;
		tready_low_seen = 1'b0;
		for (int p = 0; p < n_pkts; p++) begin
			send_packet(en, words);
		end
		@(negedge axi_aclk);
		s_axis_tvalid = 1'b0;
		while (exp_q.size() != 0) begin
			@(negedge axi_aclk);
		end
		if (bp) begin
			assert (tready_low_seen) else begin
				$display("s_axis_tready never dropped, the buffer did not fill");
				errors++;
			end
		end
		bp_enable = 1'b0;
		tests_run++;
		$display("test %s done with %0d errors", name, errors - errors_before);
	endtask

	always @(negedge axi_aclk) begin
		logic [255:0] r;
		if (bp_enable) begin
			take_bits(bp_lfsr, 2, r);
			m_axis_tready = (r[1:0] == 2'b11);   // Ready one cycle in four
		end else begin
			m_axis_tready = 1'b1;
		end
	end

	// Compare every output transfer with the head of the expected queue
	always @(posedge axi_aclk) begin
		if (axi_resetn && !s_axis_tready) begin
			tready_low_seen = 1'b1;
		end
		if (axi_resetn && m_axis_tvalid && m_axis_tready) begin
			assert (exp_q.size() != 0) else begin
				$display("output word arrived with no word expected");
				errors++;
			end
			if (exp_q.size() != 0) begin
				exp_w = exp_q.pop_front();
				words_checked++;
				assert (m_axis_tdata === exp_w.data) else begin
					$display("mismatch m_axis_tdata: got %h expected %h", m_axis_tdata, exp_w.data);
					errors++;
				end
				assert (m_axis_tstrb === exp_w.strb) else begin
					$display("mismatch m_axis_tstrb: got %h expected %h", m_axis_tstrb, exp_w.strb);
					errors++;
				end
				assert (m_axis_tuser === exp_w.user) else begin
					$display("mismatch m_axis_tuser: got %h expected %h", m_axis_tuser, exp_w.user);
					errors++;
				end
				assert (m_axis_tlast === exp_w.last) else begin
					$display("mismatch m_axis_tlast: got %h expected %h", m_axis_tlast, exp_w.last);
					errors++;
				end
			end
		end
	end

	initial begin
		repeat (watchdog_cycles) @(posedge axi_aclk);
		$display("watchdog expired after %0d cycles with %0d words still expected",
			watchdog_cycles, exp_q.size());
		$display("TESTS FAILED");
		$finish;
	end

	initial begin
		axi_aclk      = 1'b0;
		axi_resetn    = 1'b0;
		s_axis_tdata  = '0;
		s_axis_tstrb  = '0;
		s_axis_tuser  = '0;
		s_axis_tvalid = 1'b0;
		s_axis_tlast  = 1'b0;
		m_axis_tready = 1'b1;
		cut_en        = 1'b0;
		cut_words     = '0;
		stim_lfsr     = lfsr_seed;
		bp_lfsr       = lfsr_seed;
		bp_enable     = 1'b0;
		gap_enable    = 1'b0;
		errors        = 0;
		words_checked = 0;
		tests_run     = 0;
		repeat (5) @(posedge axi_aclk);
		@(negedge axi_aclk);
		axi_resetn = 1'b1;

		// Idle after reset, nothing popped and room for input
		repeat (4) begin
			@(negedge axi_aclk);
			assert (!m_axis_tvalid) else begin
				$display("m_axis_tvalid high after reset with no input");
				errors++;
			end
			assert (s_axis_tready) else begin
				$display("s_axis_tready low after reset");
				errors++;
			end
		end
		tests_run++;
		$display("test reset_state done with %0d errors", errors);

		run_test("pass_through", 1'b0, 32'd3, 20, 1'b1, 1'b0);
		run_test("cut_long", 1'b1, 32'd2, 20, 1'b1, 1'b0);
		run_test("short_packets", 1'b1, 32'd8, 20, 1'b1, 1'b0);
		run_test("zero_cut_words", 1'b1, 32'd0, 10, 1'b1, 1'b0);
		run_test("partial_strobe_cut", 1'b1, 32'd1, 20, 1'b0, 1'b0);
		run_test("back_pressure", 1'b1, 32'd4, 40, 1'b1, 1'b1);

		repeat (10) @(negedge axi_aclk);
		$display("%0d tests, %0d words checked, %0d errors", tests_run, words_checked, errors);
		if (errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

// ==== src.f ====
cutter_stream_pkg.sv
cutter_hash_pkg.sv
stream_fifo.sv
cut_control.sv
hash_accumulator.sv
output_slice.sv
packet_cutter.sv
tb_packet_cutter.sv

// ==== Bender.yml ====
package:
  name: packet_cutter

sources:
  - cutter_stream_pkg.sv
  - cutter_hash_pkg.sv
  - stream_fifo.sv
  - cut_control.sv
  - hash_accumulator.sv
  - output_slice.sv
  - packet_cutter.sv
  - target: test
    files:
      - tb_packet_cutter.sv
